// File: Bender.yml
package:
  name: ndn_forwarder

sources:
  - rtl/ndn_pkg.sv
  - rtl/pit_lookup_if.sv
  - rtl/spi_byte_rx.sv
  - rtl/fib_table.sv
  - rtl/pit_table.sv
  - rtl/ndn_forwarder.sv
  - target: test
    files:
      - verif/ndn_forwarder_chk.sv
      - verif/ndn_forwarder_tb.sv

// File: rtl/fib_table.sv
`timescale 1ns/1ps
`default_nettype none

module fib_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx_valid,
    input  ndn_pkg::byte_t       rx_data,
    pit_lookup_if.fib            pit,
    output logic                 tx_valid,
    output ndn_pkg::byte_t       tx_data,
    output logic                 pkt_done,
    output ndn_pkg::pkt_status_e pkt_status
);

    ndn_pkg::fib_state_e               state;
    logic [5:0]                        cnt;
    logic [5:0]                        pkt_len;
    logic [ndn_pkg::DATA_BYTES*8-1:0]  pkt;
    ndn_pkg::meta_t                    meta_q;
    logic                              is_data;
    logic                              hop_zero;
    logic                              last_rx;
    logic                              req_q;
    ndn_pkg::byte_t                    top_byte;
    ndn_pkg::pkt_status_e              resp_status;

    // Kind and length are known once the first byte is in meta_q
    assign is_data  = meta_q[7];
    assign hop_zero = (meta_q[5:0] == 6'd0);
    assign pkt_len  = is_data ? 6'(ndn_pkg::DATA_BYTES) : 6'(ndn_pkg::INTEREST_BYTES);

    // Byte 0 can never be the last one
    assign last_rx = rx_valid && (cnt != 6'd0) && (cnt == pkt_len - 6'd1);

    // Bytes enter at the low end, so the first byte of a packet sits at
    // byte 8 for an interest and at byte 40 for a data packet
    assign top_byte = is_data ? pkt[ndn_pkg::DATA_BYTES*8-8 +: 8]
                              : pkt[ndn_pkg::INTEREST_BYTES*8-8 +: 8];

    // Prefix lies directly below the metadata byte
    assign pit.prefix = is_data ? pkt[$bits(ndn_pkg::payload_t) +: $bits(ndn_pkg::prefix_t)]
                                : pkt[0 +: $bits(ndn_pkg::prefix_t)];
    assign pit.op     = is_data ? ndn_pkg::op_consume : ndn_pkg::op_insert;
    assign pit.req    = req_q;

    // PIT answer to packet status
    always_comb begin
        case (pit.result)
            ndn_pkg::res_ok:        resp_status = ndn_pkg::st_forwarded;
            ndn_pkg::res_duplicate: resp_status = ndn_pkg::st_aggregated;
            ndn_pkg::res_collision: resp_status = ndn_pkg::st_collision;
            default:                resp_status = ndn_pkg::st_unsolicited;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ndn_pkg::st_idle_rx;
            cnt        <= '0;
            meta_q     <= '0;
            req_q      <= 1'b0;
            pkt_status <= ndn_pkg::st_forwarded;
        end else begin
            req_q <= 1'b0;
            case (state)
                ndn_pkg::st_idle_rx: begin
                    if (rx_valid) begin
                        if (cnt == 6'd0) begin
                            meta_q <= rx_data;
                        end
                        if (last_rx) begin
                            // An expired interest never reaches the PIT
                            req_q <= is_data || !hop_zero;
                            cnt   <= '0;
                            state <= ndn_pkg::st_lookup;
                        end else begin
                            cnt <= cnt + 6'd1;
                        end
                    end
                end
                ndn_pkg::st_lookup: begin
                    if (!is_data && hop_zero) begin
                        pkt_status <= ndn_pkg::st_expired;
                        state      <= ndn_pkg::st_decide;
                    end else if (pit.resp) begin
                        pkt_status <= resp_status;
                        // Outgoing interest carries one hop less
                        if (!is_data && resp_status == ndn_pkg::st_forwarded) begin
                            meta_q[5:0] <= meta_q[5:0] - 6'd1;
                        end
                        state <= ndn_pkg::st_decide;
                    end
                end
                ndn_pkg::st_decide: begin
                    // Byte 0 goes out on this cycle
                    if (pkt_status == ndn_pkg::st_forwarded) begin
                        cnt   <= 6'd1;
                        state <= ndn_pkg::st_send;
                    end else begin
                        state <= ndn_pkg::st_idle_rx;
                    end
                end
                ndn_pkg::st_send: begin
                    if (cnt == pkt_len - 6'd1) begin
                        cnt   <= '0;
                        state <= ndn_pkg::st_idle_rx;
                    end else begin
                        cnt <= cnt + 6'd1;
                    end
                end
                default: begin
                    state <= ndn_pkg::st_idle_rx;
                end
            endcase
        end
    end

    // Same left shift for assembly and for transmission
    always_ff @(posedge clk) begin
        if (state == ndn_pkg::st_idle_rx && rx_valid) begin
            pkt <= {pkt[ndn_pkg::DATA_BYTES*8-9:0], rx_data};
        end else if (tx_valid) begin
            pkt <= pkt << 8;
        end
    end

    assign pkt_done = (state == ndn_pkg::st_decide);
    assign tx_valid = (state == ndn_pkg::st_send) ||
                      (pkt_done && pkt_status == ndn_pkg::st_forwarded);

    // Metadata comes from meta_q, which holds the rewritten hop limit
    assign tx_data = (state == ndn_pkg::st_send) ? top_byte : meta_q;

endmodule

`default_nettype wire

// File: rtl/ndn_forwarder.sv
`timescale 1ns/1ps
`default_nettype none

module ndn_forwarder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 spi_sclk,
    input  logic                 spi_cs_n,
    input  logic                 spi_mosi,
    output logic                 tx_valid,
    output ndn_pkg::byte_t       tx_data,
    output logic                 pkt_done,
    output ndn_pkg::pkt_status_e pkt_status
);

    // Byte strobe from the SPI side
    logic           rx_valid;
    ndn_pkg::byte_t rx_data;

    pit_lookup_if pit_if ();

    spi_byte_rx u_spi_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    fib_table u_fib (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .pit        (pit_if.fib),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .pkt_done   (pkt_done),
        .pkt_status (pkt_status)
    );

    pit_table u_pit (
        .clk   (clk),
        .rst_n (rst_n),
        .pit   (pit_if.pit)
    );

endmodule

`default_nettype wire

// File: rtl/ndn_pkg.sv
`default_nettype none

package ndn_pkg;

    // Packet lengths in bytes, metadata byte included
    localparam int INTEREST_BYTES = 9;
    localparam int DATA_BYTES     = 41;

    // Direct-mapped PIT
    localparam int PIT_DEPTH = 16;

    typedef logic [7:0]   byte_t;
    typedef logic [63:0]  prefix_t;
    // Bit 7 is the kind (1 = data), bit 6 rides along, bits 5:0 hop limit
    typedef logic [7:0]   meta_t;
    typedef logic [255:0] payload_t;
    typedef logic [$clog2(PIT_DEPTH)-1:0] pit_idx_t;

    typedef enum logic {
        op_insert,
        op_consume
    } pit_op_e;

    typedef enum logic [1:0] {
        res_ok,
        res_duplicate,
        res_collision,
        res_miss
    } pit_result_e;

    typedef enum logic [2:0] {
        st_forwarded,
        st_expired,
        st_aggregated,
        st_collision,
        st_unsolicited
    } pkt_status_e;

    typedef enum logic [1:0] {
        st_idle_rx,
        st_lookup,
        st_decide,
        st_send
    } fib_state_e;

endpackage

`default_nettype wire

// File: rtl/pit_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pit_lookup_if;

    // Request side, one-cycle pulse
    logic                 req;
    ndn_pkg::pit_op_e     op;
    ndn_pkg::prefix_t     prefix;

    // Answer arrives two cycles after req
    logic                 resp;
    ndn_pkg::pit_result_e result;

    modport fib (
        output req,
        output op,
        output prefix,
        input  resp,
        input  result
    );

    modport pit (
        input  req,
        input  op,
        input  prefix,
        output resp,
        output result
    );

endinterface

`default_nettype wire

// File: rtl/pit_table.sv
`timescale 1ns/1ps
`default_nettype none

module pit_table (
    input  logic      clk,
    input  logic      rst_n,
    pit_lookup_if.pit pit
);

    logic [ndn_pkg::PIT_DEPTH-1:0] slot_valid;
    ndn_pkg::prefix_t              slot_prefix [ndn_pkg::PIT_DEPTH];

    logic              stage_busy;
    ndn_pkg::pit_idx_t idx_q;
    ndn_pkg::pit_op_e  op_q;
    ndn_pkg::prefix_t  prefix_q;
    logic              hit_valid;
    logic              hit_match;
    logic              store_en;
    logic              clear_en;

    // XOR of all prefix bytes, low bits select the slot
    function automatic ndn_pkg::pit_idx_t fold_prefix(input ndn_pkg::prefix_t p);
        ndn_pkg::byte_t acc;
        acc = '0;
        for (int i = 0; i < $bits(ndn_pkg::prefix_t) / 8; i++) begin
            acc ^= p[i*8 +: 8];
        end
        return ndn_pkg::pit_idx_t'(acc);
    endfunction

    // First cycle, capture the request
    always_ff @(posedge clk) begin
        if (pit.req) begin
            idx_q    <= fold_prefix(pit.prefix);
            op_q     <= pit.op;
            prefix_q <= pit.prefix;
        end
    end

    // Second cycle, compare against the addressed slot
    assign hit_valid = slot_valid[idx_q];
    assign hit_match = hit_valid && (slot_prefix[idx_q] == prefix_q);
    assign store_en  = stage_busy && (op_q == ndn_pkg::op_insert) && !hit_valid;
    assign clear_en  = stage_busy && (op_q == ndn_pkg::op_consume) && hit_match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_busy <= 1'b0;
            pit.resp   <= 1'b0;
            slot_valid <= '0;
        end else begin
            stage_busy <= pit.req;
            pit.resp   <= stage_busy;
            if (store_en) begin
                slot_valid[idx_q] <= 1'b1;
            end else if (clear_en) begin
                // Data consumed the entry
                slot_valid[idx_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            slot_prefix[idx_q] <= prefix_q;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_busy) begin
            if (op_q == ndn_pkg::op_insert) begin
                if (!hit_valid) begin
                    pit.result <= ndn_pkg::res_ok;
                end else if (hit_match) begin
                    pit.result <= ndn_pkg::res_duplicate;
                end else begin
                    pit.result <= ndn_pkg::res_collision;
                end
            end else begin
                pit.result <= hit_match ? ndn_pkg::res_ok : ndn_pkg::res_miss;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           spi_sclk,
    input  logic           spi_cs_n,
    input  logic           spi_mosi,
    output logic           rx_valid,
    output ndn_pkg::byte_t rx_data
);

    logic [1:0] sclk_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       cs_n_prev;
    logic       sclk_rise;
    logic       cs_fall;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;

    // Two-flop synchronizers plus one extra stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 2'b00;
            cs_n_sync <= 2'b11;
            sclk_prev <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n};
            sclk_prev <= sclk_sync[1];
            cs_n_prev <= cs_n_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    // Mode 0: sample on rising sclk while selected
    assign sclk_rise = sclk_sync[1] && !sclk_prev && !cs_n_sync[1];
    assign cs_fall   = cs_n_prev && !cs_n_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cs_fall) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                // Counter wraps to 0 after the eighth bit
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_data <= {shift_q, mosi_sync[1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/ndn_pkg.sv
rtl/pit_lookup_if.sv
rtl/spi_byte_rx.sv
rtl/fib_table.sv
rtl/pit_table.sv
rtl/ndn_forwarder.sv
verif/ndn_forwarder_chk.sv
verif/ndn_forwarder_tb.sv

// File: verif/ndn_forwarder_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ndn_forwarder_chk (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 resp,
    input  ndn_pkg::fib_state_e  state,
    input  logic                 tx_valid,
    input  logic                 pkt_done
);

    // PIT answers exactly two cycles after the request
    a_resp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> ##2 resp)
        else $error("PIT resp missing two cycles after req");

    a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp |-> $past(req, 2))
        else $error("PIT resp without req two cycles earlier");

    // Only one request in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        req |=> !req [*2])
        else $error("req raised while a PIT request was outstanding");

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_done |=> !pkt_done)
        else $error("pkt_done held longer than one cycle");

    // Byte 0 leaves on the decision cycle, the rest follow back to back
    a_tx_window: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid |-> (state == ndn_pkg::st_decide) || $past(tx_valid))
        else $error("tx_valid outside a burst started on the decision cycle");

endmodule

bind fib_table ndn_forwarder_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (pit.req),
    .resp     (pit.resp),
    .state    (state),
    .tx_valid (tx_valid),
    .pkt_done (pkt_done)
);

`default_nettype wire

// File: verif/ndn_forwarder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ndn_forwarder_tb;

    localparam int SPI_HALF   = 5;
    localparam int WAIT_LIMIT = 300;

    logic                 clk;
    logic                 rst_n;
    logic                 spi_sclk;
    logic                 spi_cs_n;
    logic                 spi_mosi;
    logic                 tx_valid;
    ndn_pkg::byte_t       tx_data;
    logic                 pkt_done;
    ndn_pkg::pkt_status_e pkt_status;

    ndn_pkg::byte_t       pkt_bytes [ndn_pkg::DATA_BYTES];
    ndn_pkg::prefix_t     pool [6];
    logic                 model_valid [ndn_pkg::PIT_DEPTH];
    ndn_pkg::prefix_t     model_prefix [ndn_pkg::PIT_DEPTH];
    ndn_pkg::byte_t       tx_q [$];
    ndn_pkg::pkt_status_e done_q [$];
    logic                 tx_at_done_q [$];
    int                   checks;
    int                   errors;
    int                   timeouts;
    int                   pkt_num;

    ndn_forwarder DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi_sclk   (spi_sclk),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .pkt_done   (pkt_done),
        .pkt_status (pkt_status)
    );

    always #2 clk = ~clk;

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (tx_valid) begin
                tx_q.push_back(tx_data);
            end
            if (pkt_done) begin
                done_q.push_back(pkt_status);
                tx_at_done_q.push_back(tx_valid);
            end
        end
    end

    // XOR of the eight prefix bytes, low nibble
    function automatic ndn_pkg::pit_idx_t slot_of(input ndn_pkg::prefix_t p);
        ndn_pkg::byte_t x;
        x = 8'h00;
        for (int i = 0; i < 8; i++) begin
            x = x ^ p[8*i +: 8];
        end
        return x[3:0];
    endfunction

    task automatic clear_state();
        for (int i = 0; i < ndn_pkg::PIT_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        tx_q.delete();
        done_q.delete();
        tx_at_done_q.delete();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        clear_state();
        rst_n = 1'b1;
    endtask

    // Slots 0..3 for pool[0..3]; pool[4] collides with pool[0]
    task automatic build_pool();
        for (int i = 0; i < 4; i++) begin
            pool[i] = {$urandom, $urandom};
            pool[i][3:0] = pool[i][3:0] ^ slot_of(pool[i]) ^ 4'(i);
        end
        pool[4] = pool[0] ^ 64'h50;
        pool[5] = {$urandom, $urandom};
    endtask

    task automatic predict(input ndn_pkg::byte_t meta, input ndn_pkg::prefix_t prefix,
                           output ndn_pkg::pkt_status_e st);
        ndn_pkg::pit_idx_t idx;
        idx = slot_of(prefix);
        if (!meta[7]) begin
            if (meta[5:0] == 6'd0) begin
                st = ndn_pkg::st_expired;
            end else if (!model_valid[idx]) begin
                model_valid[idx]  = 1'b1;
                model_prefix[idx] = prefix;
                st = ndn_pkg::st_forwarded;
            end else if (model_prefix[idx] == prefix) begin
                st = ndn_pkg::st_aggregated;
            end else begin
                st = ndn_pkg::st_collision;
            end
        end else if (model_valid[idx] && model_prefix[idx] == prefix) begin
            model_valid[idx] = 1'b0;
            st = ndn_pkg::st_forwarded;
        end else begin
            st = ndn_pkg::st_unsolicited;
        end
    endtask

    // One chip-select frame per packet, mode 0, MSB first
    task automatic send_frame(input int n);
        spi_cs_n = 1'b0;
        repeat (SPI_HALF) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            for (int b = 7; b >= 0; b--) begin
                spi_sclk = 1'b0;
                spi_mosi = pkt_bytes[i][b];
                repeat (SPI_HALF) @(negedge clk);
                spi_sclk = 1'b1;
                repeat (SPI_HALF) @(negedge clk);
            end
        end
        spi_sclk = 1'b0;
        repeat (SPI_HALF) @(negedge clk);
        spi_cs_n = 1'b1;
        repeat (SPI_HALF) @(negedge clk);
    endtask

    task automatic run_packet(input logic is_data, input logic [5:0] hop,
                              input ndn_pkg::prefix_t prefix);
        int                   n;
        int                   waited;
        ndn_pkg::pkt_status_e exp_st;
        ndn_pkg::pkt_status_e got_st;
        logic                 got_tx0;
        ndn_pkg::byte_t       exp_b;
        ndn_pkg::byte_t       got_b;
        n = is_data ? ndn_pkg::DATA_BYTES : ndn_pkg::INTEREST_BYTES;
        pkt_num++;
        pkt_bytes[0] = {is_data, 1'($urandom), hop};
        for (int i = 0; i < 8; i++) begin
            pkt_bytes[1 + i] = prefix[63 - 8*i -: 8];
        end
        for (int i = 9; i < n; i++) begin
            pkt_bytes[i] = 8'($urandom);
        end
        predict(pkt_bytes[0], prefix, exp_st);
        checks++;
        assert (tx_q.size() == 0) else begin
            errors++;
            $display("Unexpected tx bytes appeared before packet %0d", pkt_num);
        end
        tx_q.delete();
        send_frame(n);
        waited = 0;
        while (done_q.size() == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (done_q.size() > 0) else begin
            timeouts++;
            $display("Timed out waiting for pkt_done on packet %0d", pkt_num);
        end
        if (done_q.size() == 0) begin
            return;
        end
        got_st  = done_q.pop_front();
        got_tx0 = tx_at_done_q.pop_front();
        checks += 2;
        assert (got_st == exp_st) else begin
            errors++;
            $display("Fail pkt_status: got %h expected %h", got_st, exp_st);
        end
        assert (got_tx0 == (exp_st == ndn_pkg::st_forwarded)) else begin
            errors++;
            $display("Fail tx_valid at pkt_done: got %h expected %h", got_tx0,
                     exp_st == ndn_pkg::st_forwarded);
        end
        if (exp_st != ndn_pkg::st_forwarded) begin
            return;
        end
        waited = 0;
        while (tx_q.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (tx_q.size() >= n) else begin
            timeouts++;
            $display("Timed out waiting for the tx burst of packet %0d", pkt_num);
        end
        for (int i = 0; i < n && tx_q.size() > 0; i++) begin
            got_b = tx_q.pop_front();
            exp_b = pkt_bytes[i];
            // Forwarded interest leaves with one hop less
            if (i == 0 && !is_data) begin
                exp_b[5:0] = pkt_bytes[0][5:0] - 6'd1;
            end
            checks++;
            assert (got_b == exp_b) else begin
                errors++;
                $display("Fail tx_data[%0d]: got %h expected %h", i, got_b, exp_b);
            end
        end
    endtask

    initial begin
        logic             is_data;
        logic [5:0]       hop;
        void'($urandom(32'h3a54));
        clk      = 1'b0;
        rst_n    = 1'b0;
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        pkt_num  = 0;
        clear_state();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        build_pool();

        run_packet(1'b0, 6'd5, pool[0]);
        run_packet(1'b0, 6'd0, pool[1]);
        run_packet(1'b0, 6'd3, pool[1]);
        run_packet(1'b0, 6'd9, pool[0]);
        run_packet(1'b0, 6'd9, pool[4]);
        run_packet(1'b1, 6'd2, pool[0]);
        run_packet(1'b1, 6'd2, pool[0]);
        run_packet(1'b1, 6'd4, pool[2]);

        // pool[1] is pending here and must be gone after reset
        apply_reset();
        run_packet(1'b1, 6'd1, pool[1]);

        for (int k = 0; k < 50 && timeouts == 0; k++) begin
            is_data = ($urandom_range(0, 9) < 4);
            hop     = ($urandom_range(0, 5) == 0) ? 6'd0 : 6'($urandom_range(1, 63));
            run_packet(is_data, hop, pool[$urandom_range(0, 5)]);
        end

        $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
